// ==== src/usb_tx_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared constants and CRC helper for the full-speed transmit path.
// Each stage imports this package inside its module body.
//////////////////////////////////////////////////////////////////////

`default_nettype none

package usb_tx_pkg;

  // 48 MHz system clock over the 12 Mbit/s full-speed bit rate
  localparam int unsigned CLKS_PER_BIT = 4;
  localparam int unsigned BIT_CNT_W    = $clog2(CLKS_PER_BIT);

  // SYNC field, sent LSB first as KJKJKJKK on the line
  localparam logic [7:0] SYNC_BYTE = 8'h80;

  // Low two PID bits of DATA0/DATA1/DATA2/MDATA
  localparam logic [1:0] PID_DATA_TYPE = 2'b11;

  // A zero is inserted after this many consecutive ones
  localparam int unsigned STUFF_RUN = 6;

  ////////////////////////////////////////////////////////////////////
  // CRC16
  ////////////////////////////////////////////////////////////////////

  localparam logic [15:0] CRC16_INIT = 16'hFFFF;
  localparam logic [15:0] CRC16_POLY = 16'h8005;

  // Folds one byte into the CRC register, LSB of the data first.
  // The register shifts towards bit 15, so bit 15 is the first CRC bit
  // on the wire. The framer sends the complement, bit-reversed per byte,
  // with register bits 15..8 as the first byte and 7..0 as the second
  function automatic logic [15:0] crc16_next(logic [15:0] crc, logic [7:0] data);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      fb = data[i] ^ c[15];
      c  = {c[14:0], 1'b0} ^ (fb ? CRC16_POLY : 16'h0000);
    end
    return c;
  endfunction

endpackage

`default_nettype wire

// ==== src/usb_bit_timer.sv ====
//////////////////////////////////////////////////////////////////////
// Bit timer. Divides the 48 MHz clock into a one-cycle strobe per bit
// time; a packet start restarts the count so each packet has a known phase.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_bit_timer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic link_reset_i,
  input  logic pkt_start_i,
  output logic bit_strobe_o
);
  import usb_tx_pkg::*;

  logic [BIT_CNT_W-1:0] cnt_q;

  assign bit_strobe_o = (cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (link_reset_i || pkt_start_i || bit_strobe_o) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Downstream stages assume at least one idle cycle between bits
  a_strobe_spacing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bit_strobe_o |=> !bit_strobe_o);

endmodule

`default_nettype wire

// ==== src/usb_tx_framer.sv ====
//////////////////////////////////////////////////////////////////////
// Packet framer. Presents the next byte of the packet as levels
// (SYNC, PID, payload, CRC16, EOP) and steps on each byte load from
// the serializer. Payload bytes are pulled from the data source.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_tx_framer (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       link_reset_i,
  input  logic       pkt_start_i,
  input  logic [3:0] pid_i,
  input  logic       tx_osc_test_mode_i,
  input  logic       tx_data_avail_i,
  input  logic [7:0] tx_data_i,
  input  logic       byte_load_i,
  output logic       tx_data_get_o,
  output logic [7:0] next_byte_o,
  output logic       next_eop_o,
  output logic       next_oe_o,
  output logic       frame_pending_o
);
  import usb_tx_pkg::*;

  typedef enum logic [2:0] {Idle, Sync, Pid, Data, Crc1, Eop, OscTest} state_e;

  state_e      state_q, state_d;
  logic [3:0]  pid_q;
  logic [15:0] crc_q;
  logic [7:0]  crc_lo;
  logic [7:0]  crc_hi;
  logic        pkt_accept;
  logic        payload_take;

  // Start is only honoured from Idle; test mode has priority
  assign pkt_accept   = (state_q == Idle) && pkt_start_i && !tx_osc_test_mode_i;
  assign payload_take = byte_load_i && (state_q == Data) && tx_data_avail_i;

  assign tx_data_get_o   = payload_take;
  assign frame_pending_o = (state_q != Idle);

  // CRC bytes go out complemented and bit-reversed
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      crc_lo[i] = ~crc_q[15-i];
      crc_hi[i] = ~crc_q[7-i];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Packet FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    next_byte_o = 8'h00;
    next_eop_o  = 1'b0;
    next_oe_o   = 1'b1;

    unique case (state_q)
      Idle: begin
        if (tx_osc_test_mode_i) begin
          state_d = OscTest;
        end else if (pkt_accept) begin
          state_d = Sync;
        end
      end

      Sync: begin
        next_byte_o = SYNC_BYTE;
        if (byte_load_i) begin
          state_d = Pid;
        end
      end

      Pid: begin
        // PID check bits in the high nibble
        next_byte_o = {~pid_q, pid_q};
        if (byte_load_i) begin
          state_d = (pid_q[1:0] == PID_DATA_TYPE) ? Data : Eop;
        end
      end

      Data: begin
        // A gap in the source ends the payload and starts the CRC
        next_byte_o = tx_data_avail_i ? tx_data_i : crc_lo;
        if (byte_load_i && !tx_data_avail_i) begin
          state_d = Crc1;
        end
      end

      Crc1: begin
        next_byte_o = crc_hi;
        if (byte_load_i) begin
          state_d = Eop;
        end
      end

      Eop: begin
        next_eop_o = 1'b1;
        if (byte_load_i) begin
          state_d = Idle;
        end
      end

      OscTest: begin
        // Zero bytes toggle the line every bit; last byte drops oe
        next_oe_o = tx_osc_test_mode_i;
        if (byte_load_i && !tx_osc_test_mode_i) begin
          state_d = Idle;
        end
      end

      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (link_reset_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Packet parameters and running CRC
  always_ff @(posedge clk_i) begin
    if (pkt_accept) begin
      pid_q <= pid_i;
      crc_q <= CRC16_INIT;
    end else if (payload_take) begin
      crc_q <= crc16_next(crc_q, tx_data_i);
    end
  end

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {Idle, Sync, Pid, Data, Crc1, Eop, OscTest});

endmodule

`default_nettype wire

// ==== src/usb_tx_serializer.sv ====
//////////////////////////////////////////////////////////////////////
// Serializer. Shifts each byte out LSB first, one bit per strobe, and
// inserts a zero after a run of ones. An EOP byte becomes SE0, SE0, J.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_tx_serializer (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       link_reset_i,
  input  logic       bit_strobe_i,
  input  logic [7:0] next_byte_i,
  input  logic       next_eop_i,
  input  logic       next_oe_i,
  input  logic       frame_pending_i,
  output logic       byte_load_o,
  output logic       tx_bit_o,
  output logic       tx_se0_o,
  output logic       tx_oe_o
);
  import usb_tx_pkg::*;

  logic [6:0] data_sh_q;
  logic       se0_sh_q;
  logic [2:0] bits_left_q;
  logic [2:0] ones_q;
  logic [2:0] run_q;
  logic       busy_q;
  logic       eop_q;
  logic       tx_bit_q;
  logic       tx_se0_q;
  logic       tx_oe_q;
  logic       stuff_now;
  logic       byte_done;

  assign tx_bit_o = tx_bit_q;
  assign tx_se0_o = tx_se0_q;
  assign tx_oe_o  = tx_oe_q;

  // ones_q includes the bit on the outputs right now
  assign byte_done = (bits_left_q == 3'd0);
  assign stuff_now = busy_q && tx_oe_q && !tx_se0_q && (ones_q == 3'(STUFF_RUN));

  // After an EOP the line goes idle once before the next frame
  assign byte_load_o = bit_strobe_i && !stuff_now && frame_pending_i &&
                       (!busy_q || (byte_done && !eop_q));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      se0_sh_q    <= 1'b0;
      bits_left_q <= '0;
      ones_q      <= '0;
      busy_q      <= 1'b0;
      eop_q       <= 1'b0;
      tx_bit_q    <= 1'b1;
      tx_se0_q    <= 1'b0;
      tx_oe_q     <= 1'b0;
    end else if (link_reset_i) begin
      se0_sh_q    <= 1'b0;
      bits_left_q <= '0;
      ones_q      <= '0;
      busy_q      <= 1'b0;
      eop_q       <= 1'b0;
      tx_bit_q    <= 1'b1;
      tx_se0_q    <= 1'b0;
      tx_oe_q     <= 1'b0;
    end else if (bit_strobe_i) begin
      if (stuff_now) begin
        // Stuffed zero, byte position holds
        tx_bit_q <= 1'b0;
        ones_q   <= '0;
      end else if (byte_load_o) begin
        busy_q      <= 1'b1;
        eop_q       <= next_eop_i;
        tx_oe_q     <= next_oe_i;
        tx_se0_q    <= next_eop_i;
        tx_bit_q    <= next_eop_i | next_byte_i[0];
        // Second SE0 of the EOP still to come
        se0_sh_q    <= next_eop_i;
        bits_left_q <= next_eop_i ? 3'd2 : 3'd7;
        ones_q      <= (!next_eop_i && next_byte_i[0]) ? ones_q + 3'd1 : 3'd0;
      end else if (busy_q && !byte_done) begin
        tx_bit_q    <= data_sh_q[0];
        tx_se0_q    <= se0_sh_q;
        se0_sh_q    <= 1'b0;
        bits_left_q <= bits_left_q - 3'd1;
        ones_q      <= (data_sh_q[0] && !se0_sh_q) ? ones_q + 3'd1 : 3'd0;
      end else if (busy_q) begin
        // Nothing more to send, release the line
        busy_q   <= 1'b0;
        eop_q    <= 1'b0;
        tx_oe_q  <= 1'b0;
        tx_se0_q <= 1'b0;
        tx_bit_q <= 1'b1;
        ones_q   <= '0;
      end
    end
  end

  // Remaining data bits; for EOP the J bit sits behind one SE0
  always_ff @(posedge clk_i) begin
    if (bit_strobe_i && !stuff_now) begin
      if (byte_load_o) begin
        data_sh_q <= next_eop_i ? 7'b000_0010 : next_byte_i[7:1];
      end else begin
        data_sh_q <= data_sh_q >> 1;
      end
    end
  end

  // Run of ones as seen by the line driver at its sample points
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q <= '0;
    end else if (link_reset_i) begin
      run_q <= '0;
    end else if (bit_strobe_i) begin
      run_q <= (tx_oe_q && !tx_se0_q && tx_bit_q) ? run_q + 3'd1 : 3'd0;
    end
  end

  a_stuff_run: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bit_strobe_i && tx_oe_o && !tx_se0_o && tx_bit_o |-> run_q < 3'(STUFF_RUN));

endmodule

`default_nettype wire

// ==== src/usb_tx_line_driver.sv ====
//////////////////////////////////////////////////////////////////////
// Line driver. NRZI-codes the serial bits, sequences the EOP, applies
// the D+/D- flip and registers every pad output.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_tx_line_driver (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic link_reset_i,
  input  logic cfg_pinflip_i,
  input  logic bit_strobe_i,
  input  logic tx_bit_i,
  input  logic tx_se0_i,
  input  logic tx_oe_i,
  output logic pkt_end_o,
  output logic usb_oe_o,
  output logic usb_d_o,
  output logic usb_se0_o,
  output logic usb_dp_o,
  output logic usb_dn_o
);

  // d_q is the differential level, 1 for J
  logic d_q, d_d;
  logic se0_q, se0_d;
  logic oe_q, oe_d;
  logic eop_q, eop_d;
  logic pkt_end_q, pkt_end_d;
  logic dp_d, dn_d;
  logic dp_q, dn_q, usb_d_q;

  always_comb begin
    d_d       = d_q;
    se0_d     = se0_q;
    oe_d      = oe_q;
    eop_d     = eop_q;
    pkt_end_d = 1'b0;

    if (link_reset_i) begin
      d_d   = 1'b1;
      se0_d = 1'b0;
      oe_d  = 1'b0;
      eop_d = 1'b0;
    end else if (bit_strobe_i) begin
      oe_d = tx_oe_i;
      if (!tx_oe_i) begin
        // Released line parks at J
        d_d       = 1'b1;
        se0_d     = 1'b0;
        eop_d     = 1'b0;
        pkt_end_d = oe_q && eop_q;
      end else if (tx_se0_i) begin
        se0_d = 1'b1;
        eop_d = 1'b1;
      end else if (eop_q) begin
        // Closing J of the EOP
        d_d   = 1'b1;
        se0_d = 1'b0;
      end else if (!tx_bit_i) begin
        d_d = ~d_q;
      end
    end
  end

  // Pin mapping, SE0 pulls both lines low
  assign dp_d = ~se0_d & (cfg_pinflip_i ? ~d_d : d_d);
  assign dn_d = ~se0_d & (cfg_pinflip_i ? d_d : ~d_d);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d_q       <= 1'b1;
      se0_q     <= 1'b0;
      oe_q      <= 1'b0;
      eop_q     <= 1'b0;
      pkt_end_q <= 1'b0;
      dp_q      <= 1'b1;
      dn_q      <= 1'b0;
      usb_d_q   <= 1'b1;
    end else begin
      d_q       <= d_d;
      se0_q     <= se0_d;
      oe_q      <= oe_d;
      eop_q     <= eop_d;
      pkt_end_q <= pkt_end_d;
      dp_q      <= dp_d;
      dn_q      <= dn_d;
      // Single-ended D follows the D+ pin
      usb_d_q   <= dp_d;
    end
  end

  assign pkt_end_o = pkt_end_q;
  assign usb_oe_o  = oe_q;
  assign usb_se0_o = se0_q;
  assign usb_d_o   = usb_d_q;
  assign usb_dp_o  = dp_q;
  assign usb_dn_o  = dn_q;

  a_no_se1: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(usb_dp_o && usb_dn_o));

endmodule

`default_nettype wire

// ==== src/usb_fs_tx_top.sv ====
//////////////////////////////////////////////////////////////////////
// Full-speed USB packet transmitter. Bit timer, framer, serializer
// and line driver in one pipeline, driven from a 48 MHz clock.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_fs_tx_top (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       link_reset_i,
  input  logic       cfg_pinflip_i,
  input  logic       tx_osc_test_mode_i,
  input  logic       pkt_start_i,
  input  logic [3:0] pid_i,
  input  logic       tx_data_avail_i,
  input  logic [7:0] tx_data_i,
  output logic       tx_data_get_o,
  output logic       pkt_end_o,
  output logic       usb_oe_o,
  output logic       usb_d_o,
  output logic       usb_se0_o,
  output logic       usb_dp_o,
  output logic       usb_dn_o
);

  logic       bit_strobe;
  logic       byte_load;
  logic [7:0] next_byte;
  logic       next_eop;
  logic       next_oe;
  logic       frame_pending;
  logic       tx_bit;
  logic       tx_se0;
  logic       tx_oe;

  usb_bit_timer u_bit_timer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .link_reset_i (link_reset_i),
    .pkt_start_i  (pkt_start_i),
    .bit_strobe_o (bit_strobe)
  );

  usb_tx_framer u_framer (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .link_reset_i       (link_reset_i),
    .pkt_start_i        (pkt_start_i),
    .pid_i              (pid_i),
    .tx_osc_test_mode_i (tx_osc_test_mode_i),
    .tx_data_avail_i    (tx_data_avail_i),
    .tx_data_i          (tx_data_i),
    .byte_load_i        (byte_load),
    .tx_data_get_o      (tx_data_get_o),
    .next_byte_o        (next_byte),
    .next_eop_o         (next_eop),
    .next_oe_o          (next_oe),
    .frame_pending_o    (frame_pending)
  );

  usb_tx_serializer u_serializer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .link_reset_i    (link_reset_i),
    .bit_strobe_i    (bit_strobe),
    .next_byte_i     (next_byte),
    .next_eop_i      (next_eop),
    .next_oe_i       (next_oe),
    .frame_pending_i (frame_pending),
    .byte_load_o     (byte_load),
    .tx_bit_o        (tx_bit),
    .tx_se0_o        (tx_se0),
    .tx_oe_o         (tx_oe)
  );

  usb_tx_line_driver u_line_driver (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .link_reset_i  (link_reset_i),
    .cfg_pinflip_i (cfg_pinflip_i),
    .bit_strobe_i  (bit_strobe),
    .tx_bit_i      (tx_bit),
    .tx_se0_i      (tx_se0),
    .tx_oe_i       (tx_oe),
    .pkt_end_o     (pkt_end_o),
    .usb_oe_o      (usb_oe_o),
    .usb_d_o       (usb_d_o),
    .usb_se0_o     (usb_se0_o),
    .usb_dp_o      (usb_dp_o),
    .usb_dn_o      (usb_dn_o)
  );

endmodule

`default_nettype wire

// ==== testbench/usb_line_monitor.svh ====
//////////////////////////////////////////////////////////////////////
// Line monitor tasks for the transmitter testbench. Included inside
// the testbench module; samples the pins once per bit, undoes NRZI
// and bit stuffing, and collects the decoded bytes in rx_bytes.
//////////////////////////////////////////////////////////////////////

localparam int LINE_SE0 = 0;
localparam int LINE_J   = 1;
localparam int LINE_K   = 2;
localparam int LINE_SE1 = 3;

// Classify the pins, J depends on the pin flip
function automatic int line_code();
  if (!usb_dp_o && !usb_dn_o) return LINE_SE0;
  if (usb_dp_o && usb_dn_o) return LINE_SE1;
  if (usb_dp_o == !cfg_pinflip_i) return LINE_J;
  return LINE_K;
endfunction

// Returns on the falling edge inside the first K bit
task automatic wait_first_k(output bit found);
  found = 1'b0;
  for (int i = 0; i < 400; i++) begin
    @(negedge clk_i);
    if (line_code() == LINE_K) begin
      found = 1'b1;
      break;
    end
  end
  // Move on towards the middle of the bit
  if (found) @(negedge clk_i);
endtask

task automatic capture_packet(input string name);
  int         code;
  int         prev;
  int         ones;
  int         nbits;
  bit         found;
  logic       rx_bit;
  logic [7:0] cur;
  rx_bytes.delete();
  rx_stuffs = 0;
  prev  = LINE_J;
  ones  = 0;
  nbits = 0;
  cur   = 8'h00;
  wait_first_k(found);
  if (!found) begin
    error_count++;
    $display("Error in %s: no K state seen after packet start", name);
    return;
  end
  code = LINE_K;
  for (int n = 0; n < 4000; n++) begin
    if (code == LINE_SE0) break;
    if (code == LINE_SE1 || !usb_oe_o) begin
      error_count++;
      $display("Error in %s: illegal line state or oe low inside packet", name);
      return;
    end
    // D follows the D+ pin in the d/se0 pin style
    if (usb_se0_o !== 1'b0 || usb_d_o !== ((code == LINE_J) ^ cfg_pinflip_i)) begin
      error_count++;
      $display("Error in %s: d/se0 pins disagree with the dp/dn line state", name);
    end
    // NRZI, no transition means a one
    rx_bit = (code == prev);
    prev   = code;
    if (ones == STUFF_RUN) begin
      if (rx_bit) begin
        error_count++;
        $display("Error in %s: no stuffed zero after six ones", name);
      end
      rx_stuffs++;
      ones = 0;
    end else begin
      ones  = rx_bit ? ones + 1 : 0;
      cur   = {rx_bit, cur[7:1]};
      nbits++;
      if (nbits == 8) begin
        rx_bytes.push_back(cur);
        nbits = 0;
      end
    end
    repeat (CLKS_PER_BIT) @(negedge clk_i);
    code = line_code();
  end
  if (nbits != 0) begin
    error_count++;
    $display("Error in %s: packet ended inside a byte", name);
  end
  // End of packet is SE0, SE0, J
  repeat (CLKS_PER_BIT) @(negedge clk_i);
  if (line_code() != LINE_SE0 || usb_se0_o !== 1'b1) begin
    error_count++;
    $display("Error in %s: second SE0 bit of the end of packet missing", name);
  end
  repeat (CLKS_PER_BIT) @(negedge clk_i);
  if (line_code() != LINE_J) begin
    error_count++;
    $display("Error in %s: J bit after the end of packet missing", name);
  end
endtask

// ==== testbench/usb_fs_tx_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the full-speed transmitter. Applies a table of packet
// tests, decodes the pins and compares against reference bytes.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_fs_tx_tb;
  import usb_tx_pkg::*;

  localparam int MODE_PKT  = 0;
  localparam int MODE_LRST = 1;
  localparam int MODE_OSC  = 2;
  localparam int FILL_LFSR = 0;
  localparam int FILL_ONES = 1;
  localparam int FILL_SAME = 2;
  localparam int NUM_TESTS = 8;

  typedef struct {
    string      name;
    logic [3:0] pid;
    int         len;
    bit         flip;
    int         mode;
    int         fill;
    int         exp_bytes;
  } test_t;

  logic       clk_i;
  logic       rst_ni;
  logic       link_reset_i;
  logic       cfg_pinflip_i;
  logic       tx_osc_test_mode_i;
  logic       pkt_start_i;
  logic [3:0] pid_i;
  logic       tx_data_avail_i;
  logic [7:0] tx_data_i;
  logic       tx_data_get_o;
  logic       pkt_end_o;
  logic       usb_oe_o;
  logic       usb_d_o;
  logic       usb_se0_o;
  logic       usb_dp_o;
  logic       usb_dn_o;

  test_t      tests [NUM_TESTS];
  logic [7:0] payload[$];
  logic [7:0] rx_bytes[$];
  logic [7:0] prev_rx[$];
  int         rx_stuffs;
  int         error_count;
  int         get_total;
  int         end_total;
  int         base_gets;
  int         feed_len;
  bit         feed_armed;
  bit         table_ready;
  logic [15:0] lfsr_q;

  `include "usb_line_monitor.svh"

  usb_fs_tx_top dut_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .link_reset_i       (link_reset_i),
    .cfg_pinflip_i      (cfg_pinflip_i),
    .tx_osc_test_mode_i (tx_osc_test_mode_i),
    .pkt_start_i        (pkt_start_i),
    .pid_i              (pid_i),
    .tx_data_avail_i    (tx_data_avail_i),
    .tx_data_i          (tx_data_i),
    .tx_data_get_o      (tx_data_get_o),
    .pkt_end_o          (pkt_end_o),
    .usb_oe_o           (usb_oe_o),
    .usb_d_o            (usb_d_o),
    .usb_se0_o          (usb_se0_o),
    .usb_dp_o           (usb_dp_o),
    .usb_dn_o           (usb_dn_o)
  );

  always #20 clk_i = ~clk_i;

  // Data source, keeps the next payload byte on the bus
  always @(posedge clk_i) begin : data_source
    int idx;
    if (tx_data_get_o) get_total <= get_total + 1;
    idx = get_total - base_gets + (tx_data_get_o ? 1 : 0);
    if (feed_armed && idx < feed_len) begin
      tx_data_avail_i <= 1'b1;
      tx_data_i       <= payload[idx];
    end else begin
      tx_data_avail_i <= 1'b0;
      tx_data_i       <= 8'h00;
    end
  end

  always @(posedge clk_i) begin
    if (pkt_end_o) end_total <= end_total + 1;
  end

  ////////////////////////////////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [7:0] next_random_byte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++) begin
      b[i]   = lfsr_q[15];
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
    end
    return b;
  endfunction

  // CRC-16/USB in reflected form, sent low byte first
  function automatic logic [15:0] crc16_ref(logic [7:0] data[$]);
    logic [15:0] r;
    logic [15:0] poly_r;
    r = CRC16_INIT;
    for (int i = 0; i < 16; i++) poly_r[i] = CRC16_POLY[15-i];
    foreach (data[k]) begin
      for (int i = 0; i < 8; i++) begin
        r = ((r[0] ^ data[k][i]) != 1'b0) ? ((r >> 1) ^ poly_r) : (r >> 1);
      end
    end
    return ~r;
  endfunction

  // Stuffed bits expected over the whole bit stream
  function automatic int expected_stuffs(logic [7:0] bytes[$]);
    int run;
    int n;
    run = 0;
    n   = 0;
    foreach (bytes[k]) begin
      for (int i = 0; i < 8; i++) begin
        run = bytes[k][i] ? run + 1 : 0;
        if (run == STUFF_RUN) begin
          n++;
          run = 0;
        end
      end
    end
    return n;
  endfunction

  task automatic report_mismatch(string name, string what, int exp, int act);
    error_count++;
    $display("Fail %s %s expected %0h actual %0h", name, what, exp, act);
  endtask

  task automatic load_table();
    tests[0] = '{"ack",          4'b0010,  0, 1'b0, MODE_PKT,  FILL_LFSR,  2};
    tests[1] = '{"data0_len0",   4'b0011,  0, 1'b0, MODE_PKT,  FILL_LFSR,  4};
    tests[2] = '{"data1_len3",   4'b1011,  3, 1'b0, MODE_PKT,  FILL_LFSR,  7};
    tests[3] = '{"data0_len16",  4'b0011, 16, 1'b0, MODE_PKT,  FILL_LFSR, 20};
    tests[4] = '{"flip_len16",   4'b0011, 16, 1'b1, MODE_PKT,  FILL_SAME, 20};
    tests[5] = '{"ones_len8",    4'b1011,  8, 1'b0, MODE_PKT,  FILL_ONES, 12};
    tests[6] = '{"link_reset",   4'b0011, 12, 1'b0, MODE_LRST, FILL_LFSR,  0};
    tests[7] = '{"osc_test",     4'b0000,  6, 1'b0, MODE_OSC,  FILL_LFSR,  0};
  endtask

  task automatic wait_oe_low(string name);
    for (int i = 0; i < 200; i++) begin
      @(posedge clk_i);
      if (!usb_oe_o) return;
    end
    error_count++;
    $display("Error in %s: usb_oe_o did not fall", name);
  endtask

  task automatic check_idle(string name);
    if (usb_oe_o !== 1'b0) report_mismatch(name, "usb_oe_o", 0, int'(usb_oe_o));
    if (line_code() != LINE_J) report_mismatch(name, "line", LINE_J, line_code());
    if (usb_se0_o !== 1'b0) report_mismatch(name, "usb_se0_o", 0, int'(usb_se0_o));
    // D follows the D+ pin, so J reads low when the pins are flipped
    if (usb_d_o !== !cfg_pinflip_i) begin
      report_mismatch(name, "usb_d_o", int'(!cfg_pinflip_i), int'(usb_d_o));
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Test sequences
  ////////////////////////////////////////////////////////////////////

  task automatic run_test(int t);
    logic [7:0] exp_q[$];
    logic [7:0] b;
    logic [15:0] crc;
    int         base_end;
    int         base_get;
    int         prev;
    int         code;
    bit         found;
    string      name;
    name = tests[t].name;
    @(posedge clk_i);
    cfg_pinflip_i <= tests[t].flip;
    repeat (4) @(posedge clk_i);
    check_idle(name);
    if (tests[t].fill != FILL_SAME) begin
      payload.delete();
      for (int i = 0; i < tests[t].len; i++) begin
        if (tests[t].fill == FILL_ONES) b = 8'hFF;
        else b = next_random_byte();
        payload.push_back(b);
      end
    end
    base_end = end_total;
    base_get = get_total;

    if (tests[t].mode == MODE_OSC) begin
      tx_osc_test_mode_i <= 1'b1;
      wait_first_k(found);
      if (!found) begin
        error_count++;
        $display("Error in %s: line never left J in test mode", name);
      end
      prev = LINE_K;
      for (int i = 0; i < 24; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk_i);
        code = line_code();
        if (code == prev || code == LINE_SE0 || code == LINE_SE1 || !usb_oe_o) begin
          report_mismatch(name, "toggle", 1, 0);
        end
        prev = code;
      end
      @(posedge clk_i);
      tx_osc_test_mode_i <= 1'b0;
      wait_oe_low(name);
      repeat (2) @(posedge clk_i);
      check_idle(name);
      if (end_total != base_end) report_mismatch(name, "pkt_end", 0, end_total - base_end);
      return;
    end

    base_gets  <= get_total;
    feed_len   <= tests[t].len;
    feed_armed <= 1'b1;
    repeat (2) @(posedge clk_i);
    pid_i       <= tests[t].pid;
    pkt_start_i <= 1'b1;
    @(posedge clk_i);
    pkt_start_i <= 1'b0;

    if (tests[t].mode == MODE_LRST) begin
      wait_first_k(found);
      repeat (8 * CLKS_PER_BIT) @(posedge clk_i);
      link_reset_i <= 1'b1;
      @(posedge clk_i);
      link_reset_i <= 1'b0;
      feed_armed   <= 1'b0;
      base_end = end_total;
      repeat (2) @(posedge clk_i);
      check_idle(name);
      repeat (20 * CLKS_PER_BIT) @(posedge clk_i);
      check_idle(name);
      if (end_total != base_end) report_mismatch(name, "pkt_end", 0, end_total - base_end);
      return;
    end

    capture_packet(name);
    @(posedge clk_i);
    feed_armed <= 1'b0;
    wait_oe_low(name);
    repeat (3 * CLKS_PER_BIT) @(posedge clk_i);
    check_idle(name);

    exp_q.push_back(SYNC_BYTE);
    exp_q.push_back({~tests[t].pid, tests[t].pid});
    if (tests[t].pid[1:0] == PID_DATA_TYPE) begin
      foreach (payload[i]) exp_q.push_back(payload[i]);
      crc = crc16_ref(payload);
      exp_q.push_back(crc[7:0]);
      exp_q.push_back(crc[15:8]);
    end
    if (exp_q.size() != tests[t].exp_bytes) begin
      error_count++;
      $display("Error in %s: table byte count does not match the packet", name);
    end
    if (rx_bytes.size() != exp_q.size()) begin
      report_mismatch(name, "byte count", exp_q.size(), rx_bytes.size());
    end else begin
      foreach (exp_q[i]) begin
        if (rx_bytes[i] !== exp_q[i]) begin
          report_mismatch(name, "byte", int'(exp_q[i]), int'(rx_bytes[i]));
        end
      end
    end
    if (rx_stuffs != expected_stuffs(exp_q)) begin
      report_mismatch(name, "stuffed bits", expected_stuffs(exp_q), rx_stuffs);
    end
    if (tests[t].fill == FILL_ONES && rx_stuffs == 0) report_mismatch(name, "stuffing", 1, 0);
    if (tests[t].fill == FILL_SAME && rx_bytes != prev_rx) begin
      error_count++;
      $display("Error in %s: flipped packet differs from the unflipped one", name);
    end
    if (end_total - base_end != 1) report_mismatch(name, "pkt_end", 1, end_total - base_end);
    if (get_total - base_get != tests[t].len) begin
      report_mismatch(name, "data gets", tests[t].len, get_total - base_get);
    end
    prev_rx = rx_bytes;
  endtask

  // Watchdog, limit scales with the table
  initial begin : watchdog
    longint limit_ns;
    limit_ns = 200000;
    wait (table_ready);
    for (int t = 0; t < NUM_TESTS; t++) begin
      limit_ns += longint'(tests[t].len + 5) * 10 * CLKS_PER_BIT * 40;
    end
    #(limit_ns * 1ns);
    $display("Error: simulation timed out after %0d ns", limit_ns);
    $display("Finished with errors");
    $finish;
  end

  initial begin : main
    clk_i              = 1'b0;
    rst_ni             = 1'b0;
    link_reset_i       = 1'b0;
    cfg_pinflip_i      = 1'b0;
    tx_osc_test_mode_i = 1'b0;
    pkt_start_i        = 1'b0;
    pid_i              = 4'h0;
    tx_data_avail_i    = 1'b0;
    tx_data_i          = 8'h00;
    error_count        = 0;
    get_total          = 0;
    end_total          = 0;
    base_gets          = 0;
    feed_len           = 0;
    feed_armed         = 1'b0;
    lfsr_q             = 16'd80;
    load_table();
    table_ready = 1'b1;

    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (4) @(posedge clk_i);
    check_idle("reset");
    if (tx_data_get_o !== 1'b0) begin
      report_mismatch("reset", "tx_data_get_o", 0, int'(tx_data_get_o));
    end
    if (end_total != 0) report_mismatch("reset", "pkt_end", 0, end_total);

    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end

    $display("Tests run %0d, errors %0d", NUM_TESTS, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+testbench
src/usb_tx_pkg.sv
src/usb_bit_timer.sv
src/usb_tx_framer.sv
src/usb_tx_serializer.sv
src/usb_tx_line_driver.sv
src/usb_fs_tx_top.sv
testbench/usb_fs_tx_tb.sv

// ==== Makefile ====
TOP := usb_fs_tx_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f all.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
